// ==== source/oversampler_defines.svh ====
/* oversampler shared constants
   widths, apb register map and reset defaults of the limit registers */

`ifndef OVERSAMPLER_DEFINES_SVH
`define OVERSAMPLER_DEFINES_SVH

// --------------------
// data path widths
`define OVS_SAMPLES        8     // samples per deserialized word
`define OVS_PHASES         4     // phase lanes, one per sample pair
`define OVS_COUNT_W        8     // hysteresis counter and limit width

// --------------------
// apb register map
`define OVS_APB_AW         4
`define OVS_ADDR_CTRL      4'h0  // invert, manual, manual_phase
`define OVS_ADDR_LIMIT     4'h4  // stable_limit, err_limit
`define OVS_ADDR_STATUS    4'h8  // phase_sel, phase_err (read only)

// even samples come from the complementary path
`define OVS_EVEN_MASK      8'h55

// limit reset values
`define OVS_STABLE_DEFAULT 8'd200
`define OVS_ERR_DEFAULT    8'd8

`endif

// ==== source/oversampler_pkg.sv ====
/* oversampler types
   sample word views, phase code and counter type */

`default_nettype none

`include "oversampler_defines.svh"

package oversampler_pkg;

  // upper half holds samples 4..7, lower half samples 0..3
  typedef struct packed {
    logic [`OVS_SAMPLES/2-1:0] upper;
    logic [`OVS_SAMPLES/2-1:0] lower;
  } sample_halves_t;

  // raw byte for the mask, halves for the lane slicing
  typedef union packed {
    logic [`OVS_SAMPLES-1:0] raw;
    sample_halves_t          half;
  } sample_word_u;

  // phase code, gray ordered around the sampling circle
  //   0 -> samples 0/4, 1 -> 1/5, 3 -> 2/6, 2 -> 3/7
  typedef logic [1:0] phase_sel_t;

  // stability and error counters, and their limits
  typedef logic [`OVS_COUNT_W-1:0] count_t;

endpackage

`default_nettype wire

// ==== source/oversampler_cfg_if.sv ====
/* oversampler configuration bundle
   register block settings fanned out to the bit recovery core */

`timescale 1ns/1ps
`default_nettype none

interface oversampler_cfg_if;

  logic                       invert;        // flip recovered bits
  logic                       manual;        // software owns the phase
  oversampler_pkg::phase_sel_t manual_phase; // phase code used in manual mode
  oversampler_pkg::count_t    stable_limit;  // good cycles before err count resets
  oversampler_pkg::count_t    err_limit;     // errors before a phase move

  // register block side
  modport regs (
    output invert,
    output manual,
    output manual_phase,
    output stable_limit,
    output err_limit
  );

  // tracker side
  modport core (
    input invert,
    input manual,
    input manual_phase,
    input stable_limit,
    input err_limit
  );

endinterface

`default_nettype wire

// ==== source/sample_capture.sv ====
/* sample capture stage
   registers the raw word and keeps an un-inverted copy one cycle later */

`timescale 1ns/1ps
`default_nettype none

`include "oversampler_defines.svh"

module sample_capture (
  input  logic                          fastclock,
  input  logic                          rst_n,
  input  logic [`OVS_SAMPLES-1:0]       sample_word,  // straight from the deserializer
  output oversampler_pkg::sample_word_u cur,          // current word, even bits still inverted
  output oversampler_pkg::sample_word_u prev          // previous word, fully corrected
);

  // --------------------
  // two stage pipe
  // cur  : cycle 1, raw
  // prev : cycle 2, even samples flipped back
  always_ff @(posedge fastclock or negedge rst_n) begin
    if (!rst_n) begin
      cur.raw  <= '0;
      prev.raw <= '0;
    end else begin
      cur.raw  <= sample_word;                  // raw view of the new word
      prev.raw <= cur.raw ^ `OVS_EVEN_MASK;     // undo complementary path
    end
  end

endmodule

`default_nettype wire

// ==== source/phase_lane.sv ====
/* phase lane
   neighbour agreement flag and candidate bit pair for one sampling phase */

`timescale 1ns/1ps
`default_nettype none

module phase_lane (
  input  logic       fastclock,
  input  logic       rst_n,
  input  logic       invert,     // output polarity
  input  logic [1:0] near_pair,  // adjacent samples, lower half
  input  logic [1:0] far_pair,   // adjacent samples, upper half
  input  logic [1:0] cand_pair,  // {upper, lower} corrected samples of this phase
  output logic       eq,         // a neighbour pair agrees
  output logic       rise,       // bit taken on the rising edge
  output logic       fall        // bit taken on the falling edge
);

  // eq is a cycle ahead of the pair, so the tracker can
  // register phase_err one stage before d0/d1
  always_ff @(posedge fastclock or negedge rst_n) begin
    if (!rst_n) begin
      eq   <= 1'b0;
      rise <= 1'b0;
      fall <= 1'b0;
    end else begin
      eq   <= (near_pair[0] == near_pair[1]) || (far_pair[0] == far_pair[1]);
      rise <= cand_pair[1] ^ invert;   // upper half sample
      fall <= cand_pair[0] ^ invert;   // lower half sample
    end
  end

  // --------------------
  // upstream capture must hand over known samples once out of reset
  ap_lane_known: assert property (
    @(posedge fastclock) disable iff (!rst_n)
    !$isunknown({eq, rise, fall})
  ) else $error("phase_lane: unknown eq/rise/fall");

endmodule

`default_nettype wire

// ==== source/phase_tracker.sv ====
/* phase tracker
   picks a sampling phase, voting with error and stability counters, and drives the bits */

`timescale 1ns/1ps
`default_nettype none

`include "oversampler_defines.svh"

module phase_tracker (
  input  logic                        fastclock,
  input  logic                        rst_n,
  oversampler_cfg_if.core             cfg,
  input  logic [`OVS_PHASES-1:0]      eq,         // per lane agreement, cycle 2
  input  logic [`OVS_PHASES-1:0]      rise,       // per lane rising bit, cycle 3
  input  logic [`OVS_PHASES-1:0]      fall,       // per lane falling bit, cycle 3
  output oversampler_pkg::phase_sel_t phase_sel,
  output logic                        phase_err,
  output logic                        d0,
  output logic                        d1
);

  logic                        err_sel;       // phase error of the current code
  logic                        rise_sel;
  logic                        fall_sel;
  oversampler_pkg::phase_sel_t phase_next;    // target of a vote
  oversampler_pkg::phase_sel_t phase_last;
  oversampler_pkg::count_t     stable_count;
  oversampler_pkg::count_t     err_count;
  logic                        link_stable;
  logic                        vote;

  // --------------------
  // lane select, code -> lane is 0->0 1->1 3->2 2->3
  always_comb begin
    case (phase_sel)
      2'd0: begin
        err_sel  = eq[0] | eq[3];
        rise_sel = rise[0];
        fall_sel = fall[0];
      end
      2'd1: begin
        err_sel  = eq[1] | eq[0];
        rise_sel = rise[1];
        fall_sel = fall[1];
      end
      2'd3: begin
        err_sel  = eq[3] | eq[2];
        rise_sel = rise[2];
        fall_sel = fall[2];
      end
      default: begin  // code 2
        err_sel  = eq[2] | eq[1];
        rise_sel = rise[3];
        fall_sel = fall[3];
      end
    endcase
  end

  // phase_err at cycle 3, d0/d1 at cycle 4
  always_ff @(posedge fastclock or negedge rst_n) begin
    if (!rst_n) begin
      phase_err <= 1'b0;
      d0        <= 1'b0;
      d1        <= 1'b0;
    end else begin
      phase_err <= err_sel;
      d0        <= rise_sel;
      d1        <= fall_sel;
    end
  end

  // --------------------
  // hysteresis
  // a long run of clean cycles forgives old errors, so a glitch
  // here and there never builds up to a move
  always_ff @(posedge fastclock or negedge rst_n) begin
    if (!rst_n) begin
      stable_count <= '0;
      err_count    <= '0;
      link_stable  <= 1'b0;
      vote         <= 1'b0;
      phase_last   <= '0;
    end else begin
      if (phase_err)
        stable_count <= '0;
      else if (stable_count < cfg.stable_limit)
        stable_count <= stable_count + 1'b1;

      link_stable <= (stable_count == cfg.stable_limit);
      phase_last  <= phase_sel;
      vote        <= (err_count == cfg.err_limit);  // enough errors, time to move

      if (link_stable || (phase_last != phase_sel))
        err_count <= '0;                            // settled, or a move is under way
      else if (err_count > cfg.err_limit)
        err_count <= cfg.err_limit;                 // limit lowered by software
      else if (phase_err && (err_count < cfg.err_limit))
        err_count <= err_count + 1'b1;
    end
  end

  // --------------------
  // move toward the lane whose neighbours agree
  always_comb begin
    phase_next = phase_sel;
    case (phase_sel)
      2'd0: begin
        if (eq[0])      phase_next = 2'd2;
        else if (eq[3]) phase_next = 2'd1;
      end
      2'd1: begin
        if (eq[1])      phase_next = 2'd0;
        else if (eq[0]) phase_next = 2'd3;
      end
      2'd3: begin
        if (eq[2])      phase_next = 2'd1;
        else if (eq[1]) phase_next = 2'd2;
      end
      default: begin
        if (eq[3])      phase_next = 2'd3;
        else if (eq[2]) phase_next = 2'd0;
      end
    endcase
  end

  always_ff @(posedge fastclock or negedge rst_n) begin
    if (!rst_n)
      phase_sel <= '0;
    else if (cfg.manual)
      phase_sel <= cfg.manual_phase;   // software choice, one cycle after the write
    else if (vote)
      phase_sel <= phase_next;
  end

  // --------------------
  // err count stays inside the limit, one cycle of slack after a limit change
  ap_err_count_limit: assert property (
    @(posedge fastclock) disable iff (!rst_n)
    (cfg.err_limit == $past(cfg.err_limit)) |-> (err_count <= cfg.err_limit)
  ) else $error("phase_tracker: err_count above err_limit");

  // the phase never drifts on its own
  ap_phase_move: assert property (
    @(posedge fastclock) disable iff (!rst_n)
    (phase_sel != $past(phase_sel)) |-> $past(vote || cfg.manual)
  ) else $error("phase_tracker: phase_sel moved without vote or manual");

endmodule

`default_nettype wire

// ==== source/oversampler_regs.sv ====
/* oversampler register block
   apb slave holding control and limit settings, returns phase status */

`timescale 1ns/1ps
`default_nettype none

`include "oversampler_defines.svh"

module oversampler_regs (
  input  logic                        fastclock,
  input  logic                        rst_n,
  input  logic [`OVS_APB_AW-1:0]      paddr,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [31:0]                 pwdata,
  output logic [31:0]                 prdata,
  output logic                        pready,
  output logic                        pslverr,
  oversampler_cfg_if.regs             cfg,
  input  oversampler_pkg::phase_sel_t phase_sel,   // live tracker state
  input  logic                        phase_err
);

  logic                        access;
  logic                        hit_ctrl;
  logic                        hit_limit;
  logic                        hit_status;
  logic                        ctrl_invert;
  logic                        ctrl_manual;
  oversampler_pkg::phase_sel_t ctrl_phase;
  oversampler_pkg::count_t     stable_limit_q;
  oversampler_pkg::count_t     err_limit_q;

  // --------------------
  // decode
  assign access     = psel & penable;             // apb access phase
  assign hit_ctrl   = (paddr == `OVS_ADDR_CTRL);
  assign hit_limit  = (paddr == `OVS_ADDR_LIMIT);
  assign hit_status = (paddr == `OVS_ADDR_STATUS);
  assign pready     = 1'b1;                       // zero wait states

  // unmapped offset or a write to the status word
  assign pslverr = access & (~(hit_ctrl | hit_limit | hit_status) | (pwrite & hit_status));

  // writes land on the access edge
  always_ff @(posedge fastclock or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_invert    <= 1'b0;
      ctrl_manual    <= 1'b0;                     // automatic tracking
      ctrl_phase     <= '0;
      stable_limit_q <= `OVS_STABLE_DEFAULT;
      err_limit_q    <= `OVS_ERR_DEFAULT;
    end else if (access && pwrite) begin
      if (hit_ctrl) begin
        ctrl_invert <= pwdata[0];
        ctrl_manual <= pwdata[1];
        ctrl_phase  <= pwdata[3:2];
      end
      if (hit_limit) begin
        stable_limit_q <= pwdata[7:0];
        err_limit_q    <= pwdata[15:8];
      end
    end
  end

  // read mux, valid during the access phase
  always_comb begin
    prdata = '0;
    if (psel) begin
      if (hit_ctrl)
        prdata[3:0] = {ctrl_phase, ctrl_manual, ctrl_invert};
      else if (hit_limit)
        prdata[15:0] = {err_limit_q, stable_limit_q};
      else if (hit_status)
        prdata[2:0] = {phase_err, phase_sel};
    end
  end

  // --------------------
  // out to the core
  assign cfg.invert       = ctrl_invert;
  assign cfg.manual       = ctrl_manual;
  assign cfg.manual_phase = ctrl_phase;
  assign cfg.stable_limit = stable_limit_q;
  assign cfg.err_limit    = err_limit_q;

  // master side protocol
  ap_penable_psel: assert property (
    @(posedge fastclock) disable iff (!rst_n)
    penable |-> psel
  ) else $error("oversampler_regs: penable without psel");

  ap_setup_access: assert property (
    @(posedge fastclock) disable iff (!rst_n)
    (psel && !penable) |=> (psel && penable)
  ) else $error("oversampler_regs: setup phase not followed by access");

endmodule

`default_nettype wire

// ==== source/oversampler_top.sv ====
/* oversampler top level
   4-phase bit recovery core with apb configuration */

`timescale 1ns/1ps
`default_nettype none

`include "oversampler_defines.svh"

module oversampler_top (
  input  logic                        fastclock,   // half the data rate
  input  logic                        rst_n,
  input  logic [`OVS_SAMPLES-1:0]     sample_word, // one word per cycle, even bits inverted
  input  logic [`OVS_APB_AW-1:0]      paddr,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [31:0]                 pwdata,
  output logic [31:0]                 prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic                        d0,          // rising edge bit
  output logic                        d1,          // falling edge bit
  output logic                        phase_err,
  output oversampler_pkg::phase_sel_t phase_sel_out
);

  oversampler_pkg::sample_word_u cur;
  oversampler_pkg::sample_word_u prev;
  logic [`OVS_PHASES-1:0]        eq;
  logic [`OVS_PHASES-1:0]        rise;
  logic [`OVS_PHASES-1:0]        fall;

  oversampler_cfg_if cfg ();

  sample_capture u_capture (
    .fastclock   (fastclock),
    .rst_n       (rst_n),
    .sample_word (sample_word),
    .cur         (cur),
    .prev        (prev)
  );

  // --------------------
  // one lane per phase, lane k looks at samples k and k+4
  for (genvar k = 0; k < `OVS_PHASES; k++) begin : g_lane
    logic [1:0] near_pair;
    logic [1:0] far_pair;
    logic [1:0] cand_pair;

    if (k < `OVS_PHASES - 1) begin : g_inner
      assign near_pair = cur.half.lower[k+1:k];
      assign far_pair  = cur.half.upper[k+1:k];
    end else begin : g_wrap
      // last lane wraps, sample 7 of the old word meets sample 0 of the new one
      assign near_pair = {cur.half.upper[0], cur.half.lower[3]};
      assign far_pair  = {prev.half.upper[3], cur.half.lower[0]};
    end

    assign cand_pair = {prev.half.upper[k], prev.half.lower[k]};

    phase_lane u_lane (
      .fastclock (fastclock),
      .rst_n     (rst_n),
      .invert    (cfg.invert),
      .near_pair (near_pair),
      .far_pair  (far_pair),
      .cand_pair (cand_pair),
      .eq        (eq[k]),
      .rise      (rise[k]),
      .fall      (fall[k])
    );
  end

  phase_tracker u_tracker (
    .fastclock (fastclock),
    .rst_n     (rst_n),
    .cfg       (cfg.core),
    .eq        (eq),
    .rise      (rise),
    .fall      (fall),
    .phase_sel (phase_sel_out),
    .phase_err (phase_err),
    .d0        (d0),
    .d1        (d1)
  );

  oversampler_regs u_regs (
    .fastclock (fastclock),
    .rst_n     (rst_n),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .cfg       (cfg.regs),
    .phase_sel (phase_sel_out),
    .phase_err (phase_err)
  );

endmodule

`default_nettype wire

// ==== dv/oversampler_checker.sv ====
/* oversampler data path checker
   keeps a history of driven words and compares d0, d1 and phase_err each cycle */

`timescale 1ns/1ps
`default_nettype none

`include "oversampler_defines.svh"

module oversampler_checker (
  input  logic                        fastclock,
  input  logic                        rst_n,
  input  logic [`OVS_SAMPLES-1:0]     sample_word,
  input  logic                        d0,
  input  logic                        d1,
  input  logic                        phase_err,
  input  oversampler_pkg::phase_sel_t phase_sel,
  input  logic                        invert,       // polarity the test has set
  input  logic                        check_en,     // low while settings change
  output int                          error_count,
  output int                          check_count
);

  logic [`OVS_SAMPLES-1:0]     hist [0:4];   // hist[n] is the word sampled n edges ago
  oversampler_pkg::phase_sel_t last_phase;
  logic                        last_invert;
  int                          settle;       // quiet cycles since phase or polarity moved

  // expected {phase_err, d0, d1} for a word and the word before it
  function automatic logic [2:0] expected_outputs(input logic [7:0] cur_raw,
                                                  input logic [7:0] prev_raw,
                                                  input logic [1:0] code,
                                                  input logic       inv);
    logic [7:0] c;
    logic [7:0] p;
    logic [3:0] edge_seen;   // a data transition next to this lane
    logic       err;
    int         lane;
    c = cur_raw ^ `OVS_EVEN_MASK;    // back to true polarity
    p = prev_raw ^ `OVS_EVEN_MASK;
    for (int k = 0; k < 3; k++)
      edge_seen[k] = (c[k] != c[k+1]) || (c[k+4] != c[k+5]);
    edge_seen[3] = (c[3] != c[4]) || (p[7] != c[0]);   // wraps into the older word
    case (code)
      2'd0: begin lane = 0; err = edge_seen[0] | edge_seen[3]; end
      2'd1: begin lane = 1; err = edge_seen[1] | edge_seen[0]; end
      2'd3: begin lane = 2; err = edge_seen[3] | edge_seen[2]; end
      default: begin lane = 3; err = edge_seen[2] | edge_seen[1]; end
    endcase
    return {err, c[lane+4] ^ inv, c[lane] ^ inv};
  endfunction

  initial begin
    error_count = 0;
    check_count = 0;
    settle      = 0;
  end

  // word history, sampled where the DUT samples it
  always @(posedge fastclock) begin
    for (int i = 4; i > 0; i--)
      hist[i] <= hist[i-1];
    hist[0] <= sample_word;
  end

  // --------------------
  // compare mid cycle, outputs are stable here
  always @(negedge fastclock) begin : compare
    logic [2:0] exp_bits;
    logic [2:0] exp_err;
    if (!rst_n || !check_en || (phase_sel !== last_phase) || (invert !== last_invert))
      settle = 0;
    else if (settle < 8)
      settle++;
    last_phase  = phase_sel;
    last_invert = invert;
    if (settle >= 5) begin                                  // pipe flushed on this phase
      exp_bits = expected_outputs(hist[3], hist[4], phase_sel, invert);   // 4 deep
      exp_err  = expected_outputs(hist[2], hist[3], phase_sel, invert);   // 3 deep
      check_count++;
      if ({d0, d1} !== exp_bits[1:0]) begin
        $display("Error at time %0t: d0/d1 %b%b, expected %b%b (phase %0d, invert %b)",
                 $time, d0, d1, exp_bits[1], exp_bits[0], phase_sel, invert);
        error_count++;
      end
      if (phase_err !== exp_err[2]) begin
        $display("Error at time %0t: phase_err %b, expected %b (phase %0d)",
                 $time, phase_err, exp_err[2], phase_sel);
        error_count++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_top.sv ====
/* oversampler testbench
   clock, reset, apb accesses and word stimulus around the bit recovery core */

`timescale 1ns/1ps
`default_nettype none

`include "oversampler_defines.svh"

module tb_top;

  localparam int BIT_OFFSET = 3;   // sample offset of the serial stream in test 5
  localparam int STABLE_LIM = 4;
  localparam int ERR_LIM    = 2;

  logic                        fastclock;
  logic                        rst_n;
  logic [`OVS_SAMPLES-1:0]     sample_word;
  logic [`OVS_APB_AW-1:0]      paddr;
  logic                        psel;
  logic                        penable;
  logic                        pwrite;
  logic [31:0]                 pwdata;
  logic [31:0]                 prdata;
  logic                        pready;
  logic                        pslverr;
  logic                        d0;
  logic                        d1;
  logic                        phase_err;
  oversampler_pkg::phase_sel_t phase_sel_out;

  logic        exp_invert;       // polarity the checker should expect
  logic        check_en;
  logic        bit_mode;         // serial stream instead of random words
  logic [31:0] lcg_state;
  logic        tx_bits [0:8191]; // true bits of the serial stream
  logic        rx_bits [0:63];
  int          tx_pos;           // first bit of the next word
  int          tx_fill;
  int          tb_errors;
  int          tb_checks;
  int          chk_errors;
  int          chk_count;
  int          reported;         // errors already shown in a test line

  oversampler_top DUT (
    .fastclock     (fastclock),
    .rst_n         (rst_n),
    .sample_word   (sample_word),
    .paddr         (paddr),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .d0            (d0),
    .d1            (d1),
    .phase_err     (phase_err),
    .phase_sel_out (phase_sel_out)
  );

  oversampler_checker u_checker (
    .fastclock   (fastclock),
    .rst_n       (rst_n),
    .sample_word (sample_word),
    .d0          (d0),
    .d1          (d1),
    .phase_err   (phase_err),
    .phase_sel   (phase_sel_out),
    .invert      (exp_invert),
    .check_en    (check_en),
    .error_count (chk_errors),
    .check_count (chk_count)
  );

  initial begin
    fastclock = 1'b0;
    forever #20 fastclock = ~fastclock;   // 40 ns period
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $finish;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    tb_checks++;
    if (got !== exp) begin
      $display("Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
      tb_errors++;
    end
  endtask

  task automatic report_test(input string name);
    int total;
    total = tb_errors + chk_errors;
    $display("test %s done, %0d new errors", name, total - reported);
    reported = total;
  endtask

  // --------------------
  // apb master drives setup then access and takes the response mid access
  task automatic apb_transfer(input logic wr, input logic [`OVS_APB_AW-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int n;
    @(posedge fastclock);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge fastclock);
    #2;
    penable = 1'b1;
    n = 0;
    do begin
      @(negedge fastclock);
      n++;
      if (n > 16) abort_run("apb transfer saw no pready within 16 cycles");
    end while (!pready);
    rdata = prdata;
    err   = pslverr;
    @(posedge fastclock);   // transfer completes on this edge
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [`OVS_APB_AW-1:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [`OVS_APB_AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    apb_transfer(1'b0, addr, 32'd0, data, err);
  endtask

  // manual mode through each phase code in turn
  task automatic run_manual_phases(input logic inv);
    logic        err;
    logic [31:0] rdata;
    for (int code = 0; code < 4; code++) begin
      check_en = 1'b0;
      apb_write(`OVS_ADDR_CTRL, (code << 2) | 32'h2 | inv, err);
      check_value("pslverr on CTRL write", err, 0);
      exp_invert = inv;
      check_en   = 1'b1;
      @(posedge fastclock);   // manual phase loads one edge after the write
      @(negedge fastclock);
      check_value("phase_sel_out after CTRL write", phase_sel_out, code);
      apb_read(`OVS_ADDR_STATUS, rdata, err);
      check_value("STATUS phase field", rdata & 32'h3, code);
      repeat (40) @(posedge fastclock);
      #2;
    end
  endtask

  // --------------------
  // word stimulus driven 2 ns after the edge
  always @(posedge fastclock) begin : drive_samples
    logic [7:0] corr;
    #2;
    if (bit_mode) begin
      while (tx_fill <= tx_pos + 2) begin   // a word can reach into the next pair
        lcg_state         = lcg_next(lcg_state);
        tx_bits[tx_fill]  = lcg_state[20];
        tx_fill++;
      end
      for (int s = 0; s < 8; s++)
        corr[s] = tx_bits[tx_pos + (s + BIT_OFFSET) / 4];  // four samples per bit
      sample_word = corr ^ `OVS_EVEN_MASK;                   // even samples go out inverted
      tx_pos += 2;
    end else begin
      lcg_state   = lcg_next(lcg_state);
      sample_word = lcg_state[23:16];
    end
  end

  initial begin : run_tests
    logic                        err;
    logic [31:0]                 rdata;
    logic                        found;
    oversampler_pkg::phase_sel_t last_phase;
    int                          n;
    int                          run;
    int                          base;
    int                          hits;
    rst_n       = 1'b0;
    sample_word = '0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    exp_invert  = 1'b0;
    check_en    = 1'b0;
    bit_mode    = 1'b0;
    lcg_state   = 32'd87;
    tx_pos      = 0;
    tx_fill     = 0;
    tb_errors   = 0;
    tb_checks   = 0;
    reported    = 0;
    repeat (16) @(posedge fastclock);
    #2;
    rst_n = 1'b1;

    // test 1 checks reset values before the first edge out of reset
    @(negedge fastclock);
    check_value("d0 after reset", d0, 0);
    check_value("d1 after reset", d1, 0);
    check_value("phase_err after reset", phase_err, 0);
    check_value("phase_sel_out after reset", phase_sel_out, 0);
    check_value("pslverr after reset", pslverr, 0);
    apb_read(`OVS_ADDR_CTRL, rdata, err);
    check_value("CTRL default", rdata, 0);
    apb_read(`OVS_ADDR_LIMIT, rdata, err);
    check_value("LIMIT default", rdata, {`OVS_ERR_DEFAULT, `OVS_STABLE_DEFAULT});
    report_test("reset");

    // test 2 covers read back and error responses
    apb_write(`OVS_ADDR_CTRL, 32'hD, err);
    apb_read(`OVS_ADDR_CTRL, rdata, err);
    check_value("CTRL read back", rdata, 32'hD);
    apb_write(`OVS_ADDR_LIMIT, 32'h3C14, err);
    apb_read(`OVS_ADDR_LIMIT, rdata, err);
    check_value("LIMIT read back", rdata, 32'h3C14);
    check_value("pslverr on LIMIT read", err, 0);
    apb_write(`OVS_ADDR_STATUS, 32'h7, err);
    check_value("pslverr on STATUS write", err, 1);
    apb_read(4'hC, rdata, err);
    check_value("pslverr on unmapped read", err, 1);
    report_test("registers");

    run_manual_phases(1'b0);
    report_test("manual data path");
    run_manual_phases(1'b1);
    report_test("invert and phase error");

    // --------------------
    // test 5 sends a serial stream and the tracker starts on a bad phase
    check_en   = 1'b0;
    exp_invert = 1'b0;
    apb_write(`OVS_ADDR_LIMIT, (ERR_LIM << 8) | STABLE_LIM, err);
    apb_write(`OVS_ADDR_CTRL, 32'h2, err);   // manual, phase 0
    @(negedge fastclock);
    bit_mode = 1'b1;
    apb_write(`OVS_ADDR_CTRL, 32'h0, err);   // hand over to the tracker
    check_en = 1'b1;
    n = 0;
    run = 0;
    last_phase = phase_sel_out;
    while (run < STABLE_LIM + 8) begin
      @(negedge fastclock);
      n++;
      if (n > 1500) abort_run("automatic tracking did not settle within 1500 cycles");
      if (phase_err || (phase_sel_out != last_phase)) run = 0;
      else run++;
      last_phase = phase_sel_out;
    end
    base = tx_pos;
    for (int j = 0; j < 32; j++) begin
      @(negedge fastclock);
      rx_bits[2*j]   = d1;   // the falling edge bit is the older one
      rx_bits[2*j+1] = d0;
      check_value("phase_err while locked", phase_err, 0);
    end
    found = 1'b0;
    for (int s = (base > 40) ? base - 40 : 0; s <= base; s++) begin
      hits = 0;
      for (int j = 0; j < 64; j++)
        if (rx_bits[j] === tx_bits[s + j]) hits++;
      if (hits == 64) found = 1'b1;
    end
    tb_checks++;
    if (!found) begin
      $display("Error at time %0t: recovered bits do not match the sent stream", $time);
      tb_errors++;
    end
    apb_read(`OVS_ADDR_STATUS, rdata, err);
    check_value("STATUS phase_err while locked", rdata & 32'h4, 0);
    report_test("automatic tracking");

    $display("5 tests, %0d checks, %0d errors", tb_checks + chk_count, tb_errors + chk_errors);
    if (chk_count == 0)
      $display("the checker made no data path comparisons");
    if ((tb_errors + chk_errors == 0) && (chk_count > 0))
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/oversampler_pkg.sv
source/oversampler_cfg_if.sv
source/sample_capture.sv
source/phase_lane.sv
source/phase_tracker.sv
source/oversampler_regs.sv
source/oversampler_top.sv
dv/oversampler_checker.sv
dv/tb_top.sv

// ==== Bender.yml ====
package:
  name: oversampler

sources:
  - include_dirs:
      - source
    files:
      - source/oversampler_pkg.sv
      - source/oversampler_cfg_if.sv
      - source/sample_capture.sv
      - source/phase_lane.sv
      - source/phase_tracker.sv
      - source/oversampler_regs.sv
      - source/oversampler_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/oversampler_checker.sv
      - dv/tb_top.sv
